// File: src/simd_pkg.sv
`default_nettype none

package simd_pkg;

	localparam int DATA_W = 64;
	localparam int ADDR_W = 32;
	localparam int REG_AW = 5;
	localparam int IMM_W = 16;
	localparam int PC_STEP = 4;

	// primary opcodes, anything else is a bubble
	typedef enum logic [0:5] {
		R_TYPE = 6'b101010,
		LW = 6'b100000,
		SW = 6'b100001,
		BEQ = 6'b100010,
		BNE = 6'b100011,
		NOP = 6'b111100
	} opcode_e;

	// r-type function field
	typedef enum logic [0:5] {
		AND = 6'b000000,
		OR = 6'b000001,
		XOR = 6'b000010,
		NOT = 6'b000011,
		MOV = 6'b000100,
		ADD = 6'b000101,
		SUB = 6'b000110,
		SHL = 6'b001010,
		SHR = 6'b001100
	} alu_func_e;

	typedef enum logic [0:1] {
		W8 = 2'b00,
		W16 = 2'b01,
		W32 = 2'b10,
		W64 = 2'b11
	} lane_width_e;

	// byte groups written back, byte 0 is the most significant
	typedef enum logic [0:2] {
		ALL = 3'b000,
		HIGH_HALF = 3'b001,
		LOW_HALF = 3'b010,
		EVEN_BYTES = 3'b011,
		ODD_BYTES = 3'b100
	} write_part_e;

	// immediate is {rb, part, width, func}
	typedef struct packed {
		opcode_e opcode;
		logic [0:REG_AW-1] rd;
		logic [0:REG_AW-1] ra;
		logic [0:REG_AW-1] rb;
		write_part_e part;
		lane_width_e width;
		alu_func_e func;
	} instr_t;

	typedef struct packed {
		alu_func_e alu_op;
		logic r_valid;
		logic is_lw;
		logic is_sw;
		logic [0:REG_AW-1] rd;
		logic [0:DATA_W-1] ra_val;
		logic [0:DATA_W-1] rb_val;
		lane_width_e width;
		write_part_e part;
		logic [0:IMM_W-1] imm;
	} id_ex_t;

	typedef struct packed {
		logic wr_en;
		logic is_lw;
		logic [0:REG_AW-1] rd;
		write_part_e part;
		logic [0:DATA_W-1] result;
	} mem_wb_t;

	// execute output toward the memory stage
	typedef struct packed {
		mem_wb_t wb;
		logic is_sw;
		logic [0:DATA_W-1] store_data;
		logic [0:ADDR_W-1] addr;
	} ex_mem_t;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic reset,
	input wire logic [0:simd_pkg::REG_AW-1] ra_idx,
	input wire logic [0:simd_pkg::REG_AW-1] rb_idx,
	input wire logic [0:simd_pkg::REG_AW-1] rd_idx,
	output logic [0:simd_pkg::DATA_W-1] ra_value,
	output logic [0:simd_pkg::DATA_W-1] rb_value,
	output logic [0:simd_pkg::DATA_W-1] rd_value,
	input wire logic wb_en,
	input wire logic [0:simd_pkg::REG_AW-1] wb_idx,
	input wire simd_pkg::write_part_e wb_part,
	input wire logic [0:simd_pkg::DATA_W-1] wb_data
);
	import simd_pkg::*;

	localparam int N_REGS = 1 << REG_AW;
	localparam int N_BYTES = DATA_W / 8;

	logic [0:DATA_W-1] regs [0:N_REGS-1];
	logic [0:DATA_W-1] wr_mask;

	// expand the write part into a bit mask
	function automatic logic [0:DATA_W-1] part_mask(input write_part_e part);
		logic [0:N_BYTES-1] bytes;
		logic [0:DATA_W-1] mask;
		case (part)
			ALL: bytes = '1;
			HIGH_HALF: bytes = {{(N_BYTES/2){1'b1}}, {(N_BYTES/2){1'b0}}};
			LOW_HALF: bytes = {{(N_BYTES/2){1'b0}}, {(N_BYTES/2){1'b1}}};
			EVEN_BYTES: bytes = {(N_BYTES/2){2'b10}};
			ODD_BYTES: bytes = {(N_BYTES/2){2'b01}};
			default: bytes = '0;
		endcase
		for (int b = 0; b < N_BYTES; b++)
			mask[b*8 +: 8] = {8{bytes[b]}};
		return mask;
	endfunction

	assign wr_mask = part_mask(wb_part);

	assign ra_value = regs[ra_idx];
	assign rb_value = regs[rb_idx];
	assign rd_value = regs[rd_idx];

	// falling edge write is visible to decode before the next rising edge
	always_ff @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < N_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_idx != '0)
		begin
			regs[wb_idx] <= (regs[wb_idx] & ~wr_mask) | (wb_data & wr_mask);
		end
	end

	wb_part_legal: assert property (@(negedge clk) disable iff (reset)
		wb_en |-> wb_part inside {ALL, HIGH_HALF, LOW_HALF, EVEN_BYTES, ODD_BYTES})
		else $error("illegal write part %b for r%0d", wb_part, wb_idx);

endmodule

`default_nettype wire

// File: src/fetch_decode.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_decode #(
	parameter logic [0:simd_pkg::ADDR_W-1] RESET_PC = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire simd_pkg::instr_t instruction,
	input wire logic [0:simd_pkg::DATA_W-1] rd_value,
	output logic [0:simd_pkg::ADDR_W-1] pc,
	output logic [0:simd_pkg::REG_AW-1] ra_idx,
	output logic [0:simd_pkg::REG_AW-1] rb_idx,
	output logic [0:simd_pkg::REG_AW-1] rd_idx,
	output simd_pkg::id_ex_t decoded
);
	import simd_pkg::*;

	instr_t ir;
	logic is_rtype;
	logic is_lw;
	logic is_sw;
	logic is_beq;
	logic is_bne;
	logic func_kept;
	logic uses_rb;
	logic take_branch;
	logic [0:IMM_W-1] imm;

	assign is_rtype = (ir.opcode == R_TYPE);
	assign is_lw = (ir.opcode == LW);
	assign is_sw = (ir.opcode == SW);
	assign is_beq = (ir.opcode == BEQ);
	assign is_bne = (ir.opcode == BNE);

	// dropped functions fall out here and become bubbles
	always_comb
	begin
		func_kept = 1'b0;
		uses_rb = 1'b0;
		case (ir.func)
			AND, OR, XOR, ADD, SUB, SHL, SHR:
			begin
				func_kept = 1'b1;
				uses_rb = 1'b1;
			end
			NOT, MOV: func_kept = 1'b1;
			default: ;
		endcase
	end

	// sw stores the register named in the rd field
	assign rd_idx = (is_rtype || is_lw || is_beq || is_bne) ? ir.rd : '0;
	assign ra_idx = is_rtype ? ir.ra : (is_sw ? ir.rd : '0);
	assign rb_idx = (is_rtype && uses_rb) ? ir.rb : '0;
	assign imm = (is_lw || is_sw || is_beq || is_bne) ?
		{ir.rb, ir.part, ir.width, ir.func} : '0;

	assign take_branch = (is_beq && rd_value == '0) || (is_bne && rd_value != '0);

	// operand values are filled in by the execute register
	always_comb
	begin
		decoded = '0;
		decoded.alu_op = ir.func;
		decoded.r_valid = is_rtype && func_kept;
		decoded.is_lw = is_lw;
		decoded.is_sw = is_sw;
		decoded.rd = rd_idx;
		decoded.width = is_rtype ? ir.width : W8;
		decoded.part = is_rtype ? ir.part : ALL;
		decoded.imm = imm;
	end

	// taken branch squashes the word fetched behind it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
			ir <= '0;
		end
		else if (take_branch)
		begin
			pc <= {{(ADDR_W-IMM_W){1'b0}}, imm};
			ir <= '0;
		end
		else
		begin
			pc <= pc + PC_STEP;
			ir <= instruction;
		end
	end

	pc_aligned: assert property (@(posedge clk) disable iff (reset) (pc % PC_STEP) == 0)
		else $error("pc %h not word aligned", pc);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input wire logic clk,
	input wire logic reset,
	input wire simd_pkg::id_ex_t decoded,
	input wire logic [0:simd_pkg::DATA_W-1] ra_value,
	input wire logic [0:simd_pkg::DATA_W-1] rb_value,
	output simd_pkg::ex_mem_t ex_out
);
	import simd_pkg::*;

	localparam int N_WIDTHS = 1 << $bits(lane_width_e);

	id_ex_t captured;
	id_ex_t ex_q;
	logic [0:DATA_W-1] op_a;
	logic [0:DATA_W-1] op_b;
	logic [0:DATA_W-1] result;
	logic [0:N_WIDTHS-1][0:DATA_W-1] width_res;

	always_comb
	begin
		captured = decoded;
		captured.ra_val = ra_value;
		captured.rb_val = rb_value;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_q <= '0;
		else
			ex_q <= captured;
	end

	assign op_a = ex_q.ra_val;
	assign op_b = ex_q.rb_val;

	// one lane-wise unit per lane width with lane 0 the most significant
	for (genvar g = 0; g < N_WIDTHS; g++)
	begin : g_width
		localparam int LANE_W = 8 << g;
		localparam int SH_W = $clog2(LANE_W);

		logic [0:DATA_W-1] res;

		always_comb
		begin
			res = '0;
			for (int l = 0; l < DATA_W / LANE_W; l++)
			begin
				// shift amount from the low bits of the same rb lane
				case (ex_q.alu_op)
					ADD: res[l*LANE_W +: LANE_W] = op_a[l*LANE_W +: LANE_W]
						+ op_b[l*LANE_W +: LANE_W];
					SUB: res[l*LANE_W +: LANE_W] = op_a[l*LANE_W +: LANE_W]
						- op_b[l*LANE_W +: LANE_W];
					SHL: res[l*LANE_W +: LANE_W] = op_a[l*LANE_W +: LANE_W]
						<< op_b[l*LANE_W + LANE_W - SH_W +: SH_W];
					SHR: res[l*LANE_W +: LANE_W] = op_a[l*LANE_W +: LANE_W]
						>> op_b[l*LANE_W + LANE_W - SH_W +: SH_W];
					default: ;
				endcase
			end
		end

		assign width_res[g] = res;
	end

	always_comb
	begin
		case (ex_q.alu_op)
			AND: result = op_a & op_b;
			OR: result = op_a | op_b;
			XOR: result = op_a ^ op_b;
			NOT: result = ~op_a;
			MOV: result = op_a;
			ADD, SUB, SHL, SHR: result = width_res[ex_q.width];
			default: result = '0;
		endcase
	end

	always_comb
	begin
		ex_out.wb.wr_en = ex_q.r_valid || ex_q.is_lw;
		ex_out.wb.is_lw = ex_q.is_lw;
		ex_out.wb.rd = ex_q.rd;
		ex_out.wb.part = ex_q.part;
		ex_out.wb.result = result;
		ex_out.is_sw = ex_q.is_sw;
		ex_out.store_data = op_a;
		// zero-extended 16-bit address
		ex_out.addr = {{(ADDR_W-IMM_W){1'b0}}, ex_q.imm};
	end

endmodule

`default_nettype wire

// File: src/mem_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module mem_writeback (
	input wire logic clk,
	input wire logic reset,
	input wire simd_pkg::ex_mem_t ex_out,
	input wire logic [0:simd_pkg::DATA_W-1] data_in,
	output logic mem_en,
	output logic mem_wr_en,
	output logic [0:simd_pkg::ADDR_W-1] mem_addr,
	output logic [0:simd_pkg::DATA_W-1] data_out,
	output logic wb_en,
	output logic [0:simd_pkg::REG_AW-1] wb_idx,
	output simd_pkg::write_part_e wb_part,
	output logic [0:simd_pkg::DATA_W-1] wb_data
);
	import simd_pkg::*;

	ex_mem_t mem_q;
	mem_wb_t wb_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mem_q <= '0;
			wb_q <= '0;
		end
		else
		begin
			mem_q <= ex_out;
			wb_q <= mem_q.wb;
		end
	end

	// strobes last only while the instruction sits in the memory stage
	assign mem_en = mem_q.wb.is_lw || mem_q.is_sw;
	assign mem_wr_en = mem_q.is_sw;
	assign mem_addr = mem_q.addr;
	assign data_out = mem_q.store_data;

	// load data arrives from memory during writeback
	assign wb_en = wb_q.wr_en;
	assign wb_idx = wb_q.rd;
	assign wb_part = wb_q.part;
	assign wb_data = wb_q.is_lw ? data_in : wb_q.result;

	store_no_wb: assert property (@(posedge clk) disable iff (reset)
		mem_wr_en |-> mem_en ##1 !wb_en)
		else $error("store at %h without mem_en or with a writeback", mem_addr);

endmodule

`default_nettype wire

// File: src/simd_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module simd_cpu #(
	parameter logic [0:simd_pkg::ADDR_W-1] RESET_PC = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire simd_pkg::instr_t instruction,
	input wire logic [0:simd_pkg::DATA_W-1] data_in,
	output logic [0:simd_pkg::ADDR_W-1] pc,
	output logic [0:simd_pkg::DATA_W-1] data_out,
	output logic [0:simd_pkg::ADDR_W-1] mem_addr,
	output logic mem_en,
	output logic mem_wr_en
);
	import simd_pkg::*;

	id_ex_t decoded;
	ex_mem_t ex_out;
	logic [0:REG_AW-1] ra_idx;
	logic [0:REG_AW-1] rb_idx;
	logic [0:REG_AW-1] rd_idx;
	logic [0:DATA_W-1] ra_value;
	logic [0:DATA_W-1] rb_value;
	logic [0:DATA_W-1] rd_value;
	logic wb_en;
	logic [0:REG_AW-1] wb_idx;
	write_part_e wb_part;
	logic [0:DATA_W-1] wb_data;

	fetch_decode #(
		.RESET_PC(RESET_PC)
	) fetch_decode_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.rd_value(rd_value),
		.pc(pc),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rd_idx(rd_idx),
		.decoded(decoded)
	);

	reg_file reg_file_i (
		.clk(clk),
		.reset(reset),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rd_idx(rd_idx),
		.ra_value(ra_value),
		.rb_value(rb_value),
		.rd_value(rd_value),
		.wb_en(wb_en),
		.wb_idx(wb_idx),
		.wb_part(wb_part),
		.wb_data(wb_data)
	);

	execute_stage execute_stage_i (
		.clk(clk),
		.reset(reset),
		.decoded(decoded),
		.ra_value(ra_value),
		.rb_value(rb_value),
		.ex_out(ex_out)
	);

	mem_writeback mem_writeback_i (
		.clk(clk),
		.reset(reset),
		.ex_out(ex_out),
		.data_in(data_in),
		.mem_en(mem_en),
		.mem_wr_en(mem_wr_en),
		.mem_addr(mem_addr),
		.data_out(data_out),
		.wb_en(wb_en),
		.wb_idx(wb_idx),
		.wb_part(wb_part),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// File: test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// stores behind a taken branch go here and must never show up
localparam logic [15:0] SQUASH_ADDR = 16'h00f0;
localparam int PROG_MAX = 1024;

logic [31:0] prog [0:PROG_MAX-1];
logic [31:0] exp_next [0:PROG_MAX-1];
logic [31:0] exp_addr [0:63];
logic [63:0] exp_data [0:63];
logic [63:0] ref_reg [0:31];
logic [63:0] ref_mem [0:255];
logic [31:0] test_end_pc [0:5];
int prog_len;
int n_exp;
int n_lw;
int next_store;

function automatic logic [31:0] rtype_word(alu_func_e f, lane_width_e w, write_part_e p,
	int rd, int ra, int rb);
	return {R_TYPE, 5'(rd), 5'(ra), 5'(rb), p, w, f};
endfunction

// immediate sits in the low 16 bits
function automatic logic [31:0] imm_word(opcode_e op, int rd, logic [15:0] imm);
	return {op, 5'(rd), 5'b0, imm};
endfunction

task automatic push(logic [31:0] word);
	prog[prog_len] = word;
	prog_len++;
endtask

// three bubbles keep every dependence out of reach of the pipeline
task automatic pad();
	for (int i = 0; i < 3; i++)
		push({NOP, 26'b0});
endtask

task automatic load_reg(int rd, int addr);
	push(imm_word(LW, rd, 16'(addr)));
	if (rd != 0)
		ref_reg[rd] = ref_mem[addr];
	n_lw++;
	pad();
endtask

task automatic run_alu(alu_func_e f, lane_width_e w, write_part_e p, int rd, int ra, int rb);
	push(rtype_word(f, w, p, rd, ra, rb));
	if (rd != 0)
		ref_reg[rd] = part_merge(p, ref_reg[rd], alu_model(f, w, ref_reg[ra], ref_reg[rb]));
	pad();
endtask

task automatic store_reg(int rs);
	push(imm_word(SW, rs, 16'(next_store)));
	exp_addr[n_exp] = next_store;
	exp_data[n_exp] = ref_reg[rs];
	ref_mem[next_store] = ref_reg[rs];
	n_exp++;
	next_store++;
	pad();
endtask

// taken target lies past the squashed slot and one skipped slot
task automatic branch_over(opcode_e op, int rd);
	int at;
	logic taken;
	at = prog_len;
	taken = (op == BEQ) ? (ref_reg[rd] == 0) : (ref_reg[rd] != 0);
	push(imm_word(op, rd, 16'((at + 3) * 4)));
	if (taken)
	begin
		push(imm_word(SW, 1, SQUASH_ADDR));
		push(imm_word(SW, 1, SQUASH_ADDR));
		exp_next[at + 1] = (at + 3) * 4;
		pad();
	end
	else
		store_reg(1);
endtask

task automatic end_test(int k);
	push({NOP, 26'b0});
	push({NOP, 26'b0});
	test_end_pc[k] = prog_len * 4;
endtask

task automatic build_program();
	int seed;
	alu_func_e logic_ops [0:4];
	alu_func_e arith_ops [0:1];
	alu_func_e shift_ops [0:1];
	write_part_e parts [0:3];
	seed = 40;
	logic_ops = '{AND, OR, XOR, NOT, MOV};
	arith_ops = '{ADD, SUB};
	shift_ops = '{SHL, SHR};
	parts = '{HIGH_HALF, LOW_HALF, EVEN_BYTES, ODD_BYTES};
	prog_len = 0;
	n_exp = 0;
	n_lw = 0;
	next_store = 64;
	for (int i = 0; i < PROG_MAX; i++)
	begin
		prog[i] = {NOP, 26'b0};
		exp_next[i] = (i + 1) * 4;
	end
	for (int i = 0; i < 32; i++)
		ref_reg[i] = '0;
	for (int i = 0; i < 256; i++)
	begin
		ref_mem[i] = {$random(seed), $random(seed)};
		dmem[i] = ref_mem[i];
	end
	for (int i = 0; i < 4; i++)
		push({NOP, 26'b0});
	end_test(0);
	load_reg(1, 0);
	load_reg(2, 1);
	foreach (logic_ops[i])
	begin
		run_alu(logic_ops[i], W64, ALL, 3, 1, 2);
		store_reg(3);
	end
	end_test(1);
	for (int w = 0; w < 4; w++)
		foreach (arith_ops[i])
		begin
			run_alu(arith_ops[i], lane_width_e'(w), ALL, 3, 1, 2);
			store_reg(3);
		end
	end_test(2);
	for (int w = 0; w < 4; w++)
		foreach (shift_ops[i])
		begin
			run_alu(shift_ops[i], lane_width_e'(w), ALL, 3, 1, 2);
			store_reg(3);
		end
	end_test(3);
	foreach (parts[i])
	begin
		load_reg(5, 4 + i);
		run_alu(ADD, W16, parts[i], 5, 5, 2);
		store_reg(5);
	end
	end_test(4);
	branch_over(BEQ, 0);
	branch_over(BNE, 1);
	branch_over(BEQ, 1);
	end_test(5);
endtask

`endif

// File: test/simd_cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module simd_cpu_tb;
	import simd_pkg::*;

	localparam int N_TESTS = 6;

	logic clk;
	logic reset;
	instr_t instruction;
	logic [63:0] data_in;
	logic [31:0] pc;
	logic [63:0] data_out;
	logic [31:0] mem_addr;
	logic mem_en;
	logic mem_wr_en;

	logic [63:0] dmem [0:255];
	logic rd_pend;
	logic [7:0] rd_addr;
	logic built;
	logic [31:0] model_pc;
	int store_idx;
	int mem_en_seen;
	int errors;
	int errs_before;
	int cur_test;
	int timeout_ns;
	string test_name [0:N_TESTS-1];

	// lane-wise model with lanes taken from the low end upward
	function automatic logic [63:0] alu_model(alu_func_e f, lane_width_e w,
		logic [63:0] a, logic [63:0] b);
		int lw;
		logic [63:0] lane_mask;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] r;
		logic [63:0] res;
		case (f)
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			NOT: return ~a;
			MOV: return a;
			default: ;
		endcase
		lw = 8 << int'(w);
		lane_mask = (lw == 64) ? '1 : (64'd1 << lw) - 1;
		res = '0;
		for (int j = 0; j < 64; j += lw)
		begin
			x = (a >> j) & lane_mask;
			y = (b >> j) & lane_mask;
			case (f)
				ADD: r = x + y;
				SUB: r = x - y;
				SHL: r = x << (y % lw);
				SHR: r = x >> (y % lw);
				default: r = '0;
			endcase
			res |= (r & lane_mask) << j;
		end
		return res;
	endfunction

	// byte 0 is the most significant byte
	function automatic logic [63:0] part_merge(write_part_e p, logic [63:0] old_v,
		logic [63:0] new_v);
		logic [63:0] m;
		case (p)
			ALL: m = '1;
			HIGH_HALF: m = 64'hffff_ffff_0000_0000;
			LOW_HALF: m = 64'h0000_0000_ffff_ffff;
			EVEN_BYTES: m = 64'hff00_ff00_ff00_ff00;
			ODD_BYTES: m = 64'h00ff_00ff_00ff_00ff;
			default: m = '0;
		endcase
		return (old_v & ~m) | (new_v & m);
	endfunction

	`include "tb_program.svh"

	simd_cpu dut_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.data_in(data_in),
		.pc(pc),
		.data_out(data_out),
		.mem_addr(mem_addr),
		.mem_en(mem_en),
		.mem_wr_en(mem_wr_en)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	// combinational instruction memory
	assign instruction = instr_t'(prog[pc[11:2]]);

	// data memory sampled mid-cycle and answered one cycle later
	always @(negedge clk)
	begin
		rd_pend <= 1'b0;
		if (!reset && mem_en)
		begin
			if (mem_wr_en)
				dmem[mem_addr[7:0]] <= data_out;
			else
			begin
				rd_pend <= 1'b1;
				rd_addr <= mem_addr[7:0];
			end
		end
	end

	always @(posedge clk)
	begin
		#1;
		if (rd_pend)
			data_in <= dmem[rd_addr];
	end

	always @(posedge clk)
		if (!reset && mem_wr_en)
			store_idx <= store_idx + 1;

	always @(posedge clk)
		if (!reset && mem_en)
			mem_en_seen <= mem_en_seen + 1;

	// reference pc walks the table of expected successors
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			model_pc <= '0;
		else
			model_pc <= exp_next[model_pc[11:2]];
	end

	always @(negedge clk)
	begin
		if (!reset && cur_test < N_TESTS && pc == test_end_pc[cur_test])
		begin
			$display("test %0d %s done, %0d errors", cur_test + 1, test_name[cur_test],
				errors - errs_before);
			errs_before = errors;
			cur_test++;
		end
	end

	reset_quiet: assert property (@(posedge clk) $past(reset) |-> !mem_en && !mem_wr_en)
	else
	begin
		errors++;
		$display("memory strobes not idle right after reset at %0t", $time);
	end

	pc_next: assert property (@(posedge clk) disable iff (reset) pc == model_pc)
	else
	begin
		errors++;
		$display("Fail time %0t signal pc expected %h got %h", $time,
			$sampled(model_pc), $sampled(pc));
	end

	mem_en_pulse: assert property (@(posedge clk) disable iff (reset) mem_en |=> !mem_en)
	else
	begin
		errors++;
		$display("mem_en stayed high for more than one cycle at %0t", $time);
	end

	store_data_ok: assert property (@(posedge clk) disable iff (reset)
		mem_wr_en |-> data_out == exp_data[store_idx])
	else
	begin
		errors++;
		$display("Fail time %0t signal data_out expected %h got %h", $time,
			exp_data[$sampled(store_idx)], $sampled(data_out));
	end

	store_addr_ok: assert property (@(posedge clk) disable iff (reset)
		mem_wr_en |-> mem_addr == exp_addr[store_idx])
	else
	begin
		errors++;
		$display("Fail time %0t signal mem_addr expected %h got %h", $time,
			exp_addr[$sampled(store_idx)], $sampled(mem_addr));
	end

	squashed_store: assert property (@(posedge clk) disable iff (reset)
		mem_wr_en |-> mem_addr != SQUASH_ADDR)
	else
	begin
		errors++;
		$display("store behind a taken branch reached memory at %0t", $time);
	end

	initial
	begin
		reset = 1'b1;
		data_in = '0;
		rd_pend = 1'b0;
		rd_addr = '0;
		store_idx = 0;
		mem_en_seen = 0;
		errors = 0;
		errs_before = 0;
		cur_test = 0;
		built = 1'b0;
		test_name = '{"reset", "logic", "add_sub", "shift", "partial_write", "branch"};
		build_program();
		timeout_ns = (prog_len + 60) * 10;
		built = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		wait (cur_test == N_TESTS);
		repeat (5) @(posedge clk);
		if (store_idx != n_exp)
		begin
			errors++;
			$display("only %0d of %0d expected stores were seen", store_idx, n_exp);
		end
		if (mem_en_seen != n_lw + n_exp)
		begin
			errors++;
			$display("mem_en was high in %0d cycles instead of %0d", mem_en_seen,
				n_lw + n_exp);
		end
		$display("tests %0d, stores %0d, errors %0d", cur_test, store_idx, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog scaled to the program length
	initial
	begin
		wait (built);
		#(timeout_ns);
		$display("timeout, the program never reached its last test");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: simd_cpu.f
+incdir+test
src/simd_pkg.sv
src/reg_file.sv
src/fetch_decode.sv
src/execute_stage.sv
src/mem_writeback.sv
src/simd_cpu.sv
test/simd_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= simd_cpu_tb
FILELIST ?= simd_cpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All checks passed
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
